// ==== rtl/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_W   = 32;
    localparam int AREG_W   = 5;
    localparam int NUM_AREG = 1 << AREG_W;
    localparam int PC_W     = 32;

    // instruction class as seen by retirement
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_BRANCH = 2'd3
    } op_e;

    // only alu and load produce a register result
    function automatic logic op_writes_reg(op_e op);
        return (op == OP_ALU) || (op == OP_LOAD);
    endfunction

endpackage

// ==== rtl/rob_pkg.sv ====
package rob_pkg;

    ////////////////////////////////////////////////////////////
    // reorder buffer sizing
    ////////////////////////////////////////////////////////////

    // entry count, a power of two so the pointers wrap on their own
    localparam int ROB_DEPTH = 16;

    // entry index width
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

    // credit counter must reach ROB_DEPTH itself
    localparam int CREDIT_W  = $clog2(ROB_DEPTH + 1);

endpackage

// ==== rtl/rob_dispatch.sv ====
module rob_dispatch import cpu_isa_pkg::*, rob_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // in-order instruction source
    input  logic                 in_valid_i,
    input  op_e                  in_op_i,
    input  logic [AREG_W-1:0]    in_areg_i,
    input  logic [PC_W-1:0]      in_pc_i,
    output logic                 in_ready_o,
    output logic [ROB_IDX_W-1:0] in_idx_o,

    // from retirement
    input  logic                 retire_i,
    input  logic                 flush_i,

    // entry write into the buffer
    output logic                 alloc_valid_o,
    output logic [ROB_IDX_W-1:0] alloc_idx_o,
    output op_e                  alloc_op_o,
    output logic [AREG_W-1:0]    alloc_areg_o,
    output logic [PC_W-1:0]      alloc_pc_o
);

    logic [ROB_IDX_W-1:0] alloc_ptr_q;
    logic [CREDIT_W-1:0]  credit_q;
    logic                 accept;

    ////////////////////////////////////////////////////////////
    // acceptance
    ////////////////////////////////////////////////////////////

    // a free entry exists and no flush is pending
    assign in_ready_o = (credit_q != '0) && !flush_i;
    assign accept     = in_valid_i && in_ready_o;

    // the index handed out is simply the tail pointer
    assign in_idx_o = alloc_ptr_q;

    assign alloc_valid_o = accept;
    assign alloc_idx_o   = alloc_ptr_q;
    assign alloc_op_o    = in_op_i;
    assign alloc_areg_o  = in_areg_i;
    assign alloc_pc_o    = in_pc_i;

    ////////////////////////////////////////////////////////////
    // tail pointer and free-entry credits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alloc_ptr_q <= '0;
            credit_q    <= CREDIT_W'(ROB_DEPTH);
        end else if (flush_i) begin
            // buffer is emptied, every entry is free again
            alloc_ptr_q <= '0;
            credit_q    <= CREDIT_W'(ROB_DEPTH);
        end else begin
            if (accept) begin
                alloc_ptr_q <= alloc_ptr_q + ROB_IDX_W'(1);
            end

            // accept and retire together leave the count alone
            if (accept && !retire_i) begin
                credit_q <= credit_q - CREDIT_W'(1);
            end else if (!accept && retire_i) begin
                credit_q <= credit_q + CREDIT_W'(1);
            end
        end
    end

endmodule

// ==== rtl/rob.sv ====
module rob import cpu_isa_pkg::*, rob_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // allocation from dispatch
    input  logic                 alloc_valid_i,
    input  logic [ROB_IDX_W-1:0] alloc_idx_i,
    input  op_e                  alloc_op_i,
    input  logic [AREG_W-1:0]    alloc_areg_i,
    input  logic [PC_W-1:0]      alloc_pc_i,

    // out-of-order completion
    input  logic                 cpl_valid_i,
    input  logic [ROB_IDX_W-1:0] cpl_idx_i,
    input  logic [DATA_W-1:0]    cpl_data_i,
    input  logic                 cpl_exc_i,

    // from retirement
    input  logic                 retire_i,
    input  logic                 flush_i,

    // oldest entry
    output logic                 head_valid_o,
    output op_e                  head_op_o,
    output logic [AREG_W-1:0]    head_areg_o,
    output logic [DATA_W-1:0]    head_data_o,
    output logic [PC_W-1:0]      head_pc_o,
    output logic                 head_exc_o
);

    ////////////////////////////////////////////////////////////
    // entry tables
    ////////////////////////////////////////////////////////////

    // status bits per entry
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] cmpl_q;

    // instruction fields, written at allocation
    op_e                  op_q   [ROB_DEPTH];
    logic [AREG_W-1:0]    areg_q [ROB_DEPTH];
    logic [PC_W-1:0]      pc_q   [ROB_DEPTH];

    // result fields, written at completion
    logic [DATA_W-1:0]    data_q [ROB_DEPTH];
    logic                 exc_q  [ROB_DEPTH];

    // oldest entry
    logic [ROB_IDX_W-1:0] head_q;

    logic                 cpl_hit;

    // stale completions (e.g. after a flush) find no valid entry
    assign cpl_hit = cpl_valid_i && valid_q[cpl_idx_i];

    ////////////////////////////////////////////////////////////
    // status bits and head pointer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            cmpl_q  <= '0;
            head_q  <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
            cmpl_q  <= '0;
            head_q  <= '0;
        end else begin
            // new entry starts out not yet executed
            if (alloc_valid_i) begin
                valid_q[alloc_idx_i] <= 1'b1;
                cmpl_q[alloc_idx_i]  <= 1'b0;
            end

            if (cpl_hit) begin
                cmpl_q[cpl_idx_i] <= 1'b1;
            end

            // pop the head
            if (retire_i) begin
                valid_q[head_q] <= 1'b0;
                cmpl_q[head_q]  <= 1'b0;
                head_q          <= head_q + ROB_IDX_W'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (alloc_valid_i) begin
            op_q[alloc_idx_i]   <= alloc_op_i;
            areg_q[alloc_idx_i] <= alloc_areg_i;
            pc_q[alloc_idx_i]   <= alloc_pc_i;
        end

        if (cpl_hit) begin
            data_q[cpl_idx_i] <= cpl_data_i;
            exc_q[cpl_idx_i]  <= cpl_exc_i;
        end
    end

    // head is ready to retire once it holds a result
    assign head_valid_o = valid_q[head_q] && cmpl_q[head_q];
    assign head_op_o    = op_q[head_q];
    assign head_areg_o  = areg_q[head_q];
    assign head_data_o  = data_q[head_q];
    assign head_pc_o    = pc_q[head_q];
    assign head_exc_o   = exc_q[head_q];

endmodule

// ==== rtl/rob_commit.sv ====
module rob_commit import cpu_isa_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,

    // oldest entry from the buffer
    input  logic              head_valid_i,
    input  op_e               head_op_i,
    input  logic [AREG_W-1:0] head_areg_i,
    input  logic [DATA_W-1:0] head_data_i,
    input  logic [PC_W-1:0]   head_pc_i,
    input  logic              head_exc_i,

    // retirement port
    input  logic              commit_ready_i,
    output logic              commit_valid_o,
    output op_e               commit_op_o,
    output logic [AREG_W-1:0] commit_areg_o,
    output logic [DATA_W-1:0] commit_data_o,
    output logic [PC_W-1:0]   commit_pc_o,
    output logic              commit_exc_o,

    // to buffer and dispatch
    output logic              retire_o,
    output logic              flush_o,

    // architectural register read
    input  logic [AREG_W-1:0] arf_raddr_i,
    output logic [DATA_W-1:0] arf_rdata_o
);

    logic [DATA_W-1:0] arf_q [NUM_AREG];
    logic              arf_we;
    logic              flush_q;

    ////////////////////////////////////////////////////////////
    // retirement handshake
    ////////////////////////////////////////////////////////////

    // nothing retires while the flush is being applied
    assign commit_valid_o = head_valid_i && !flush_q;
    assign retire_o       = commit_valid_o && commit_ready_i;

    assign commit_op_o   = head_op_i;
    assign commit_areg_o = head_areg_i;
    assign commit_data_o = head_data_i;
    assign commit_pc_o   = head_pc_i;
    assign commit_exc_o  = head_exc_i;

    ////////////////////////////////////////////////////////////
    // architectural register file
    ////////////////////////////////////////////////////////////

    // faulting instructions and r0 never update state
    assign arf_we = retire_o
                    && op_writes_reg(head_op_i)
                    && (head_areg_i != '0)
                    && !head_exc_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_AREG; i++) begin
                arf_q[i] <= '0;
            end
        end else if (arf_we) begin
            arf_q[head_areg_i] <= head_data_i;
        end
    end

    // r0 is hardwired
    assign arf_rdata_o = (arf_raddr_i == '0) ? '0 : arf_q[arf_raddr_i];

    ////////////////////////////////////////////////////////////
    // flush
    ////////////////////////////////////////////////////////////

    // one-cycle pulse after an exception retires
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= retire_o && head_exc_i;
        end
    end

    assign flush_o = flush_q;

endmodule

// ==== rtl/rob_top.sv ====
module rob_top import cpu_isa_pkg::*, rob_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // dispatch port
    input  logic                 in_valid_i,
    input  op_e                  in_op_i,
    input  logic [AREG_W-1:0]    in_areg_i,
    input  logic [PC_W-1:0]      in_pc_i,
    output logic                 in_ready_o,
    output logic [ROB_IDX_W-1:0] in_idx_o,

    // completion port
    input  logic                 cpl_valid_i,
    input  logic [ROB_IDX_W-1:0] cpl_idx_i,
    input  logic [DATA_W-1:0]    cpl_data_i,
    input  logic                 cpl_exc_i,

    // retirement port
    output logic                 commit_valid_o,
    output op_e                  commit_op_o,
    output logic [AREG_W-1:0]    commit_areg_o,
    output logic [DATA_W-1:0]    commit_data_o,
    output logic [PC_W-1:0]      commit_pc_o,
    output logic                 commit_exc_o,
    input  logic                 commit_ready_i,
    output logic                 flush_o,

    // register file read
    input  logic [AREG_W-1:0]    arf_raddr_i,
    output logic [DATA_W-1:0]    arf_rdata_o
);

    // dispatch to buffer
    logic                 alloc_valid;
    logic [ROB_IDX_W-1:0] alloc_idx;
    op_e                  alloc_op;
    logic [AREG_W-1:0]    alloc_areg;
    logic [PC_W-1:0]      alloc_pc;

    // buffer to retirement
    logic                 head_valid;
    op_e                  head_op;
    logic [AREG_W-1:0]    head_areg;
    logic [DATA_W-1:0]    head_data;
    logic [PC_W-1:0]      head_pc;
    logic                 head_exc;

    // retirement back to both
    logic                 retire;
    logic                 flush;

    assign flush_o = flush;

    rob_dispatch u_dispatch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_op_i       (in_op_i),
        .in_areg_i     (in_areg_i),
        .in_pc_i       (in_pc_i),
        .in_ready_o    (in_ready_o),
        .in_idx_o      (in_idx_o),
        .retire_i      (retire),
        .flush_i       (flush),
        .alloc_valid_o (alloc_valid),
        .alloc_idx_o   (alloc_idx),
        .alloc_op_o    (alloc_op),
        .alloc_areg_o  (alloc_areg),
        .alloc_pc_o    (alloc_pc)
    );

    rob u_rob (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .alloc_valid_i (alloc_valid),
        .alloc_idx_i   (alloc_idx),
        .alloc_op_i    (alloc_op),
        .alloc_areg_i  (alloc_areg),
        .alloc_pc_i    (alloc_pc),
        .cpl_valid_i   (cpl_valid_i),
        .cpl_idx_i     (cpl_idx_i),
        .cpl_data_i    (cpl_data_i),
        .cpl_exc_i     (cpl_exc_i),
        .retire_i      (retire),
        .flush_i       (flush),
        .head_valid_o  (head_valid),
        .head_op_o     (head_op),
        .head_areg_o   (head_areg),
        .head_data_o   (head_data),
        .head_pc_o     (head_pc),
        .head_exc_o    (head_exc)
    );

    rob_commit u_commit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .head_valid_i   (head_valid),
        .head_op_i      (head_op),
        .head_areg_i    (head_areg),
        .head_data_i    (head_data),
        .head_pc_i      (head_pc),
        .head_exc_i     (head_exc),
        .commit_ready_i (commit_ready_i),
        .commit_valid_o (commit_valid_o),
        .commit_op_o    (commit_op_o),
        .commit_areg_o  (commit_areg_o),
        .commit_data_o  (commit_data_o),
        .commit_pc_o    (commit_pc_o),
        .commit_exc_o   (commit_exc_o),
        .retire_o       (retire),
        .flush_o        (flush),
        .arf_raddr_i    (arf_raddr_i),
        .arf_rdata_o    (arf_rdata_o)
    );

endmodule

// ==== tests/rob_assert.sv ====
module rob_assert import rob_pkg::*, cpu_isa_pkg::*; (
    input logic                 clk,
    input logic                 rst_n_i,
    input logic                 in_valid_i,
    input logic                 in_ready_i,
    input logic [ROB_IDX_W-1:0] in_idx_i,
    input logic [ROB_DEPTH-1:0] entry_valid_i,
    input logic                 commit_valid_i,
    input logic                 commit_ready_i,
    input logic [AREG_W-1:0]    commit_areg_i,
    input logic [DATA_W-1:0]    commit_data_i,
    input logic [PC_W-1:0]      commit_pc_i,
    input logic                 commit_exc_i,
    input logic                 flush_i
);

    // an accept must land on an entry that is not occupied
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (in_valid_i && in_ready_i) |-> !entry_valid_i[in_idx_i])
        else $error("instruction accepted with no free entry");

    // stalled retirement keeps the head on the port
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (commit_valid_i && !commit_ready_i) |=>
            (commit_valid_i && $stable(commit_pc_i) && $stable(commit_data_i)
             && $stable(commit_areg_i) && $stable(commit_exc_i)))
        else $error("commit outputs changed while the sink stalled");

    // buffer is empty right after a flush
    assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !commit_valid_i)
        else $error("commit offered in the cycle after a flush");

endmodule

bind rob_top rob_assert u_assert (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .in_ready_i     (in_ready_o),
    .in_idx_i       (in_idx_o),
    .entry_valid_i  (u_rob.valid_q),
    .commit_valid_i (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_areg_i  (commit_areg_o),
    .commit_data_i  (commit_data_o),
    .commit_pc_i    (commit_pc_o),
    .commit_exc_i   (commit_exc_o),
    .flush_i        (flush_o)
);

// ==== tests/rob_tb.sv ====
module rob_tb import cpu_isa_pkg::*, rob_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic                 clk;
    logic                 rst_n_i;
    logic                 in_valid_i;
    op_e                  in_op_i;
    logic [AREG_W-1:0]    in_areg_i;
    logic [PC_W-1:0]      in_pc_i;
    logic                 in_ready_o;
    logic [ROB_IDX_W-1:0] in_idx_o;
    logic                 cpl_valid_i;
    logic [ROB_IDX_W-1:0] cpl_idx_i;
    logic [DATA_W-1:0]    cpl_data_i;
    logic                 cpl_exc_i;
    logic                 commit_valid_o;
    op_e                  commit_op_o;
    logic [AREG_W-1:0]    commit_areg_o;
    logic [DATA_W-1:0]    commit_data_o;
    logic [PC_W-1:0]      commit_pc_o;
    logic                 commit_exc_o;
    logic                 commit_ready_i;
    logic                 flush_o;
    logic [AREG_W-1:0]    arf_raddr_i;
    logic [DATA_W-1:0]    arf_rdata_o;

    // expected architectural registers
    logic [DATA_W-1:0] arf_exp [NUM_AREG];
    integer            seed = 16;
    int                err_cnt;
    int                fail_cnt;
    int                test_cnt;
    string             test_name;

    rob_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string what, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("Error %s: %s expected %0h, actual %0h", test_name, what, exp_val, act_val);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        err_cnt        = 0;
        rst_n_i        = 1'b0;
        in_valid_i     = 1'b0;
        in_op_i        = OP_ALU;
        in_areg_i      = '0;
        in_pc_i        = '0;
        cpl_valid_i    = 1'b0;
        cpl_idx_i      = '0;
        cpl_data_i     = '0;
        cpl_exc_i      = 1'b0;
        commit_ready_i = 1'b1;
        arf_raddr_i    = '0;
        for (int r = 0; r < NUM_AREG; r++) begin
            arf_exp[r] = '0;
        end
        repeat (10) @(posedge clk);
        #10;
        rst_n_i = 1'b1;
    endtask

    task automatic finish_test();
        test_cnt++;
        if (err_cnt == 0) begin
            $display("%s: passed", test_name);
        end else begin
            $display("%s: failed with %0d error(s)", test_name, err_cnt);
            fail_cnt++;
        end
    endtask

    // holds the instruction on the port until it is taken
    task automatic dispatch(input op_e op, input logic [AREG_W-1:0] areg,
                            input logic [PC_W-1:0] pc, output logic [ROB_IDX_W-1:0] idx);
        int waited;
        waited     = 0;
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_areg_i  = areg;
        in_pc_i    = pc;
        @(negedge clk);
        while (!in_ready_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready_o) begin
            $display("%s: dispatch port never became ready", test_name);
            err_cnt++;
        end
        idx = in_idx_o;
        @(posedge clk);
        #10;
        in_valid_i = 1'b0;
    endtask

    task automatic complete(input logic [ROB_IDX_W-1:0] idx, input logic [DATA_W-1:0] data,
                            input logic exc);
        cpl_valid_i = 1'b1;
        cpl_idx_i   = idx;
        cpl_data_i  = data;
        cpl_exc_i   = exc;
        @(posedge clk);
        #10;
        cpl_valid_i = 1'b0;
        cpl_exc_i   = 1'b0;
    endtask

    // waits for one retirement and updates the register model
    task automatic expect_commit(input op_e op, input logic [AREG_W-1:0] areg,
                                 input logic [PC_W-1:0] pc, input logic [DATA_W-1:0] data,
                                 input logic exc);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!commit_valid_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!commit_valid_o) begin
            $display("%s: instruction at pc %0h never retired", test_name, pc);
            err_cnt++;
        end else begin
            check("commit pc", pc, commit_pc_o);
            check("commit op", 32'(op), 32'(commit_op_o));
            check("commit areg", 32'(areg), 32'(commit_areg_o));
            check("commit data", data, commit_data_o);
            check("commit exc", 32'(exc), 32'(commit_exc_o));
            // alu and load results reach the register file unless r0 or faulting
            if ((op == OP_ALU || op == OP_LOAD) && areg != '0 && !exc) begin
                arf_exp[areg] = data;
            end
        end
        @(posedge clk);
        #10;
    endtask

    task automatic check_regs();
        for (int r = 0; r < NUM_AREG; r++) begin
            arf_raddr_i = AREG_W'(r);
            @(negedge clk);
            check("register read", arf_exp[r], arf_rdata_o);
            @(posedge clk);
            #10;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_ooo_complete();
        logic [ROB_IDX_W-1:0] idx  [4];
        logic [DATA_W-1:0]    data [4];
        start_test("ooo_complete");
        for (int i = 0; i < 4; i++) begin
            data[i] = $random(seed);
            dispatch(OP_ALU, AREG_W'(i + 1), PC_W'(32'h1000 + 4 * i), idx[i]);
            check("dispatch index", i, 32'(idx[i]));
        end
        for (int i = 3; i >= 0; i--) begin
            complete(idx[i], data[i], 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            expect_commit(OP_ALU, AREG_W'(i + 1), PC_W'(32'h1000 + 4 * i), data[i], 1'b0);
        end
        finish_test();
    endtask

    task automatic test_regfile_rule();
        op_e                  ops  [5] = '{OP_ALU, OP_LOAD, OP_STORE, OP_BRANCH, OP_ALU};
        logic [ROB_IDX_W-1:0] idx  [5];
        logic [DATA_W-1:0]    data [5];
        logic [AREG_W-1:0]    areg [5];
        start_test("regfile_rule");
        for (int i = 0; i < 5; i++) begin
            // last alu targets r0
            areg[i] = (i == 4) ? '0 : AREG_W'(i + 5);
            data[i] = $random(seed);
            dispatch(ops[i], areg[i], PC_W'(32'h1800 + 4 * i), idx[i]);
        end
        for (int i = 4; i >= 0; i--) begin
            complete(idx[i], data[i], 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            expect_commit(ops[i], areg[i], PC_W'(32'h1800 + 4 * i), data[i], 1'b0);
        end
        check_regs();
        finish_test();
    endtask

    task automatic test_credit_exhaustion();
        logic [DATA_W-1:0] data;
        int                accepted;
        int                waited;
        logic              full;
        start_test("credit_exhaustion");
        accepted   = 0;
        waited     = 0;
        full       = 1'b0;
        data       = $random(seed);
        in_valid_i = 1'b1;
        in_op_i    = OP_ALU;
        in_areg_i  = AREG_W'(9);
        while (!full && waited < TIMEOUT) begin
            in_pc_i = PC_W'(32'h2000 + 4 * accepted);
            @(negedge clk);
            full = !in_ready_o;
            if (!full) begin
                accepted++;
            end
            waited++;
            @(posedge clk);
            #10;
        end
        in_valid_i = 1'b0;
        if (!full) begin
            $display("%s: dispatch port never ran out of credits", test_name);
            err_cnt++;
        end
        check("accepted count", ROB_DEPTH, accepted);
        // retiring the oldest entry frees the slot the wrapped tail points at
        complete('0, data, 1'b0);
        expect_commit(OP_ALU, AREG_W'(9), PC_W'(32'h2000), data, 1'b0);
        @(negedge clk);
        check("ready after retire", 1, 32'(in_ready_o));
        check("next index", 0, 32'(in_idx_o));
        @(posedge clk);
        #10;
        finish_test();
    endtask

    task automatic test_backpressure();
        logic [ROB_IDX_W-1:0] idx  [2];
        logic [DATA_W-1:0]    data [2];
        int                   waited;
        start_test("backpressure");
        waited         = 0;
        commit_ready_i = 1'b0;
        arf_raddr_i    = AREG_W'(10);
        for (int i = 0; i < 2; i++) begin
            data[i] = $random(seed);
            dispatch(OP_LOAD, AREG_W'(i + 10), PC_W'(32'h3000 + 4 * i), idx[i]);
        end
        complete(idx[0], data[0], 1'b0);
        complete(idx[1], data[1], 1'b0);
        @(negedge clk);
        while (!commit_valid_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!commit_valid_o) begin
            $display("%s: completed head was never offered", test_name);
            err_cnt++;
        end
        repeat (4) begin
            @(posedge clk);
            #10;
            @(negedge clk);
            check("stalled valid", 1, 32'(commit_valid_o));
            check("stalled pc", 32'h3000, commit_pc_o);
            check("no write while stalled", 0, arf_rdata_o);
        end
        @(posedge clk);
        #10;
        commit_ready_i = 1'b1;
        expect_commit(OP_LOAD, AREG_W'(10), PC_W'(32'h3000), data[0], 1'b0);
        expect_commit(OP_LOAD, AREG_W'(11), PC_W'(32'h3004), data[1], 1'b0);
        check_regs();
        finish_test();
    endtask

    task automatic test_exception_flush();
        logic [ROB_IDX_W-1:0] idx  [4];
        logic [DATA_W-1:0]    data [4];
        logic [ROB_IDX_W-1:0] new_idx;
        start_test("exception_flush");
        for (int i = 0; i < 4; i++) begin
            data[i] = $random(seed);
            dispatch(OP_ALU, AREG_W'(i + 20), PC_W'(32'h4000 + 4 * i), idx[i]);
        end
        // faulting entry first so the older one retires right after
        complete(idx[1], data[1], 1'b1);
        complete(idx[0], data[0], 1'b0);
        expect_commit(OP_ALU, AREG_W'(20), PC_W'(32'h4000), data[0], 1'b0);
        expect_commit(OP_ALU, AREG_W'(21), PC_W'(32'h4004), data[1], 1'b1);
        @(negedge clk);
        check("flush pulse", 1, 32'(flush_o));
        check("ready during flush", 0, 32'(in_ready_o));
        @(posedge clk);
        #10;
        // late results for squashed entries
        complete(idx[2], data[2], 1'b0);
        complete(idx[3], data[3], 1'b0);
        repeat (8) begin
            @(negedge clk);
            check("squashed entry retired", 0, 32'(commit_valid_o));
            check("flush pulse length", 0, 32'(flush_o));
            @(posedge clk);
            #10;
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dispatch(OP_STORE, '0, PC_W'(32'h5000 + 4 * i), new_idx);
            check("index after flush", i, 32'(new_idx));
        end
        check_regs();
        finish_test();
    endtask

    initial begin
        fail_cnt = 0;
        test_cnt = 0;
        test_ooo_complete();
        test_regfile_rule();
        test_credit_exhaustion();
        test_backpressure();
        test_exception_flush();
        $display("tests run: %0d, tests failed: %0d", test_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/cpu_isa_pkg.sv
rtl/rob_pkg.sv
rtl/rob_dispatch.sv
rtl/rob.sv
rtl/rob_commit.sv
rtl/rob_top.sv
tests/rob_assert.sv
tests/rob_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the reorder buffer testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module rob_tb -f vlog.f \
    && ./obj_dir/Vrob_tb > sim.log 2>&1 \
    || echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -q "^>>> PASS$" sim.log \
    && echo "result: passed" \
    || { echo "result: failed"; exit 1; }
